// File: src/accumulate_execute.sv
`timescale 1ns/100ps

`include "calc_consts.svh"

module accumulate_execute
(
    input  logic                    rst,
    input  logic                    clk_100hz,
    input  logic                    key_valid,
    input  calc_key_pkg::key_kind_t key_kind,
    input  calc_key_pkg::key_word_u key_word,
    calc_result_if.exec_mp          res
);
    import calc_key_pkg::*;

    logic signed [`CALC_WIDTH-1:0] term;
    logic signed [`CALC_WIDTH-1:0] acc;
    calc_op_t                      pend_op;
    logic                          err_q;      // sticky divide by zero
    logic                          req_q;
    logic                          drain;      // req down, waiting for ack low
    logic                          busy;
    logic                          take;
    logic                          is_equ;
    logic signed [`CALC_WIDTH-1:0] op_result;
    logic                          op_divz;

    assign busy    = req_q | drain;
    assign take    = key_valid & ~busy;   // events while busy are lost
    assign is_equ  = (key_kind == KEY_OP) && (key_word.op == OP_EQU);
    assign res.req = req_q;

    // accumulator combined with term by the pending operator
    always_comb
    begin
        op_divz = 1'b0;
        case (pend_op)
            OP_ADD: op_result = acc + term;
            OP_SUB: op_result = acc - term;
            OP_MUL: op_result = acc * term;   // low bits only
            OP_DIV:
            begin
                if (term == 0)
                begin
                    op_result = '0;
                    op_divz   = 1'b1;
                end
                else
                    op_result = acc / term;   // truncates toward zero
            end
            default: op_result = acc;
        endcase
    end

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            term    <= '0;
            acc     <= '0;
            pend_op <= OP_ADD;
            err_q   <= 1'b0;
            req_q   <= 1'b0;
            drain   <= 1'b0;
        end
        else
        begin
            if (req_q && res.ack)
            begin
                req_q <= 1'b0;
                drain <= 1'b1;
            end
            else if (drain && !res.ack)
                drain <= 1'b0;

            if (take)
            begin
                if (key_kind == KEY_DIGIT)
                    term <= term * 10 + {{(`CALC_WIDTH-4){1'b0}}, key_word.digit};
                else if (is_equ)
                begin
                    // next calculation starts from zero with add
                    acc     <= '0;
                    term    <= '0;
                    err_q   <= 1'b0;
                    pend_op <= OP_ADD;
                    req_q   <= 1'b1;
                end
                else
                begin
                    acc     <= op_result;
                    err_q   <= err_q | op_divz;
                    term    <= '0;
                    pend_op <= key_word.op;
                end
            end
        end
    end

    // total stays put for the whole handshake
    always_ff @(posedge rst)
    begin
        if (take && is_equ)
        begin
            res.total   <= op_result;
            res.div_err <= err_q | op_divz;
        end
    end

endmodule

// File: src/bcd_result.sv
`timescale 1ns/100ps

`include "calc_consts.svh"

module bcd_result
(
    input  logic                         rst,
    input  logic                         clk_100hz,
    calc_result_if.res_mp                res,
    output calc_result_pkg::bcd_result_t result_bcd,
    output logic                         result_neg,
    output logic                         result_err,
    output logic                         result_done
);
    import calc_result_pkg::*;

    localparam int CNT_W = $clog2(`CALC_WIDTH + 1);

    logic                     ack_q;
    logic                     conv;       // shift-and-add-3 running
    logic [CNT_W-1:0]         step_cnt;
    logic                     start;
    logic                     finish;
    logic [`CALC_WIDTH-1:0]   mag;
    logic                     neg_q;
    logic                     err_q;
    bcd_result_t              bcd_work;
    logic [4*`CALC_DIGITS-1:0] bcd_adj;

    assign res.ack = ack_q;
    assign start   = res.req & ~ack_q & ~conv;
    assign finish  = conv && (step_cnt == CNT_W'(`CALC_WIDTH));

    // add 3 to every digit above 4 before the shift
    always_comb
    begin
        for (int i = 0; i < `CALC_DIGITS; i++)
            bcd_adj[4*i +: 4] = (bcd_work[i] > 4'd4) ? bcd_work[i] + 4'd3 : bcd_work[i];
    end

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            ack_q       <= 1'b0;
            conv        <= 1'b0;
            step_cnt    <= '0;
            result_bcd  <= '0;
            result_neg  <= 1'b0;
            result_err  <= 1'b0;
            result_done <= 1'b0;
        end
        else
        begin
            result_done <= 1'b0;
            if (start)
            begin
                conv     <= 1'b1;
                step_cnt <= '0;
            end
            else if (finish)
            begin
                conv        <= 1'b0;
                ack_q       <= 1'b1;
                result_done <= 1'b1;
                result_bcd  <= bcd_work;
                result_neg  <= neg_q;
                result_err  <= err_q;
            end
            else if (conv)
                step_cnt <= step_cnt + 1'b1;
            else if (ack_q && !res.req)
                ack_q <= 1'b0;   // last phase
        end
    end

    // sign-magnitude, then one bit per cycle msb first
    always_ff @(posedge rst)
    begin
        if (start)
        begin
            neg_q    <= res.total[`CALC_WIDTH-1];
            err_q    <= res.div_err;
            mag      <= res.total[`CALC_WIDTH-1] ? -res.total : res.total;
            bcd_work <= '0;
        end
        else if (conv && !finish)
        begin
            bcd_work <= {bcd_adj[4*`CALC_DIGITS-2:0], mag[`CALC_WIDTH-1]};
            mag      <= {mag[`CALC_WIDTH-2:0], 1'b0};
        end
    end

endmodule

// File: src/calc_consts.svh
`ifndef CALC_CONSTS_SVH
`define CALC_CONSTS_SVH

// accumulator and term width
`define CALC_WIDTH 32

// BCD digits out of the converter
// 10 digits hold the magnitude 2^31
`define CALC_DIGITS 10

// key groups on the keypad
`define NUM_DIGIT_KEYS 10
`define NUM_OP_KEYS 5

`endif

// File: src/calc_key_pkg.sv
package calc_key_pkg;

    // what a key event carries
    typedef enum logic
    {
        KEY_DIGIT = 1'b0,
        KEY_OP    = 1'b1
    } key_kind_t;

    // operator keys in index order 0 to 4
    typedef enum logic [3:0]
    {
        OP_ADD = 4'd0,
        OP_SUB = 4'd1,
        OP_MUL = 4'd2,
        OP_DIV = 4'd3,
        OP_EQU = 4'd4
    } calc_op_t;

    // one key word, read by key_kind
    typedef union packed
    {
        logic [3:0] digit;  // 0..9
        calc_op_t   op;
    } key_word_u;

endpackage

// File: src/calc_result_if.sv
`timescale 1ns/100ps

`include "calc_consts.svh"

// four-phase transfer of the finished total
// req up, ack up, req down, ack down
interface calc_result_if;

    logic                          req;
    logic                          ack;
    logic signed [`CALC_WIDTH-1:0] total;    // held while req or ack high
    logic                          div_err;  // a divide by zero happened

    modport exec_mp
    (
        output req,
        output total,
        output div_err,
        input  ack
    );

    modport res_mp
    (
        input  req,
        input  total,
        input  div_err,
        output ack
    );

endinterface

// File: src/calc_result_pkg.sv
`include "calc_consts.svh"

package calc_result_pkg;

    typedef logic [3:0] bcd_digit_t;

    // digit 0 is the least significant
    typedef bcd_digit_t [`CALC_DIGITS-1:0] bcd_result_t;

endpackage

// File: src/calculator_top.sv
`timescale 1ns/100ps

`include "calc_consts.svh"

module calculator_top
(
    input  logic                         rst,
    input  logic                         clk_100hz,
    input  logic [`NUM_DIGIT_KEYS-1:0]   digit_keys,
    input  logic [`NUM_OP_KEYS-1:0]      op_keys,   // add, sub, mul, div, equals
    output calc_result_pkg::bcd_result_t result_bcd,
    output logic                         result_neg,
    output logic                         result_err,
    output logic                         result_done
);
    import calc_key_pkg::*;

    logic      key_valid;
    key_kind_t key_kind;
    key_word_u key_word;

    // execute to result handshake
    calc_result_if res_bus ();

    key_decode u_key_decode
    (
        .rst        (rst),
        .clk_100hz  (clk_100hz),
        .digit_keys (digit_keys),
        .op_keys    (op_keys),
        .key_valid  (key_valid),
        .key_kind   (key_kind),
        .key_word   (key_word)
    );

    accumulate_execute u_accumulate_execute
    (
        .rst       (rst),
        .clk_100hz (clk_100hz),
        .key_valid (key_valid),
        .key_kind  (key_kind),
        .key_word  (key_word),
        .res       (res_bus.exec_mp)
    );

    bcd_result u_bcd_result
    (
        .rst         (rst),
        .clk_100hz   (clk_100hz),
        .res         (res_bus.res_mp),
        .result_bcd  (result_bcd),
        .result_neg  (result_neg),
        .result_err  (result_err),
        .result_done (result_done)
    );

endmodule

// File: src/key_decode.sv
`timescale 1ns/100ps

`include "calc_consts.svh"

module key_decode
(
    input  logic                        rst,
    input  logic                        clk_100hz,
    input  logic [`NUM_DIGIT_KEYS-1:0]  digit_keys,
    input  logic [`NUM_OP_KEYS-1:0]     op_keys,
    output logic                        key_valid,
    output calc_key_pkg::key_kind_t     key_kind,
    output calc_key_pkg::key_word_u     key_word
);
    import calc_key_pkg::*;

    logic [`NUM_DIGIT_KEYS-1:0] digit_s1;
    logic [`NUM_DIGIT_KEYS-1:0] digit_s2;
    logic [`NUM_OP_KEYS-1:0]    op_s1;
    logic [`NUM_OP_KEYS-1:0]    op_s2;
    logic                       any_key;
    logic                       any_d;
    logic                       key_rise;
    key_kind_t                  kind_next;
    key_word_u                  word_next;

    assign any_key  = (|digit_s2) | (|op_s2);
    assign key_rise = any_key & ~any_d;   // first key after all released

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            digit_s1  <= '0;
            digit_s2  <= '0;
            op_s1     <= '0;
            op_s2     <= '0;
            any_d     <= 1'b0;
            key_valid <= 1'b0;
        end
        else
        begin
            digit_s1  <= digit_keys;
            digit_s2  <= digit_s1;
            op_s1     <= op_keys;
            op_s2     <= op_s1;
            any_d     <= any_key;
            key_valid <= key_rise;
        end
    end

    // lowest index wins, digits over operators
    always_comb
    begin
        kind_next = KEY_DIGIT;
        word_next = '0;
        for (int i = `NUM_OP_KEYS - 1; i >= 0; i--)
        begin
            if (op_s2[i])
            begin
                kind_next    = KEY_OP;
                word_next.op = calc_op_t'(i);
            end
        end
        for (int i = `NUM_DIGIT_KEYS - 1; i >= 0; i--)
        begin
            if (digit_s2[i])
            begin
                kind_next       = KEY_DIGIT;
                word_next.digit = 4'(i);
            end
        end
    end

    // code held with the strobe
    always_ff @(posedge rst)
    begin
        if (key_rise)
        begin
            key_kind <= kind_next;
            key_word <= word_next;
        end
    end

endmodule

// File: test/calculator_assert.sv
`timescale 1ns/100ps

`include "calc_consts.svh"

module calculator_assert
(
    input logic                         rst,
    input logic                         clk_100hz,
    input logic                         req,
    input logic                         ack,
    input logic                         result_done,
    input calc_result_pkg::bcd_result_t result_bcd
);
    import calc_result_pkg::*;

    function automatic bit digits_ok(input bcd_result_t bcd);
        bit ok;
        ok = 1'b1;
        for (int i = 0; i < `CALC_DIGITS; i++)
        begin
            if (bcd[i] > 4'd9)
                ok = 1'b0;
        end
        return ok;
    endfunction

    ack_needs_req: assert property (@(posedge rst) disable iff (clk_100hz)
        $rose(ack) |-> req)
        else $error("ack rose while req was low");

    // execute may only drop req after ack
    req_holds: assert property (@(posedge rst) disable iff (clk_100hz)
        (req && !ack) |=> req)
        else $error("req dropped before ack");

    done_on_ack: assert property (@(posedge rst) disable iff (clk_100hz)
        result_done |-> $rose(ack))
        else $error("result_done outside the rising cycle of ack");

    bcd_digits: assert property (@(posedge rst) disable iff (clk_100hz)
        result_done |-> digits_ok(result_bcd))
        else $error("result digit above 9");

endmodule

bind bcd_result calculator_assert u_calc_assert
(
    .rst         (rst),
    .clk_100hz   (clk_100hz),
    .req         (res.req),
    .ack         (res.ack),
    .result_done (result_done),
    .result_bcd  (result_bcd)
);

// File: test/calculator_tb.sv
`timescale 1ns/100ps

`include "calc_consts.svh"

module calculator_tb;
    import calc_key_pkg::*;
    import calc_result_pkg::*;

    localparam int N_TAB    = 8;
    localparam int N_RND    = 8;
    localparam int MAX_KEYS = 14;
    localparam int MAX_HOLD = 40;
    localparam int WATCHDOG_CYCLES = 10 + (N_TAB + N_RND) * (MAX_KEYS * (MAX_HOLD + 5) + 60);

    logic                       rst;        // clock
    logic                       clk_100hz;  // reset
    logic [`NUM_DIGIT_KEYS-1:0] digit_keys;
    logic [`NUM_OP_KEYS-1:0]    op_keys;
    bcd_result_t                result_bcd;
    logic                       result_neg;
    logic                       result_err;
    logic                       result_done;

    int          errors = 0;
    int          checks = 0;
    int          done_count = 0;
    string       cur_case = "reset";
    logic [15:0] lfsr_state = 16'd40;

    // key string, hold cycles, expected total, negative flag, error flag
    string              tab_keys [N_TAB] = '{"12-40=", "2+3*4=", "0-7/2=", "9/0=", "5+6=",
                                             "2147483647+1=", "7*8=", "6="};
    int                 tab_hold [N_TAB] = '{5, 5, 5, 5, 5, 5, 40, 5};
    logic signed [31:0] tab_val  [N_TAB] = '{-32'sd28, 32'sd20, -32'sd3, 32'sd0, 32'sd11,
                                             32'sh80000000, 32'sd56, 32'sd6};
    bit                 tab_neg  [N_TAB] = '{1, 0, 1, 0, 0, 1, 0, 0};
    bit                 tab_err  [N_TAB] = '{0, 0, 0, 1, 0, 0, 0, 0};

    calculator_top dut
    (
        .rst         (rst),
        .clk_100hz   (clk_100hz),
        .digit_keys  (digit_keys),
        .op_keys     (op_keys),
        .result_bcd  (result_bcd),
        .result_neg  (result_neg),
        .result_err  (result_err),
        .result_done (result_done)
    );

    initial rst = 1'b0;
    always #20 rst = ~rst;

    always @(posedge rst)
    begin
        if (result_done)
            done_count <= done_count + 1;
    end

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (exp !== act)
        begin
            errors++;
            $display("ERR %s expected %0h actual %0h", name, exp, act);
        end
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int unsigned rand_bits(input int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = (v << 1) | lfsr_state[0];
        end
        return v;
    endfunction

    // operator key for a 2-bit code
    function automatic byte op_char(input int unsigned code);
        case (code)
            1: return "-";
            2: return "*";
            3: return "/";
            default: return "+";
        endcase
    endfunction

    // decimal digits of the magnitude with digit 0 lowest
    function automatic logic [63:0] to_bcd(input longint unsigned mag);
        logic [63:0] bcd;
        bcd = '0;
        for (int i = 0; i < `CALC_DIGITS; i++)
        begin
            bcd[4*i +: 4] = mag % 10;
            mag = mag / 10;
        end
        return bcd;
    endfunction

    // left to right with no precedence and 32-bit wrap
    task automatic model_eval(input string keys, output logic signed [31:0] total,
                              output logic err);
        logic signed [31:0] acc;
        logic signed [31:0] term;
        calc_op_t           op;
        byte                c;
        acc = 0;
        term = 0;
        op = OP_ADD;
        err = 1'b0;
        total = 0;
        for (int i = 0; i < keys.len(); i++)
        begin
            c = keys[i];
            if (c >= "0" && c <= "9")
                term = term * 10 + (c - 8'h30);
            else
            begin
                case (op)
                    OP_SUB: total = acc - term;
                    OP_MUL: total = acc * term;
                    OP_DIV:
                    begin
                        if (term == 0)
                        begin
                            total = 0;
                            err = 1'b1;
                        end
                        else
                            total = acc / term;
                    end
                    default: total = acc + term;
                endcase
                acc = total;
                term = 0;
                case (c)
                    "-": op = OP_SUB;
                    "*": op = OP_MUL;
                    "/": op = OP_DIV;
                    default: op = OP_ADD;
                endcase
            end
        end
    endtask

    task automatic press_key(input byte c, input int hold);
        @(negedge rst);
        if (c >= "0" && c <= "9")
            digit_keys[c - 8'h30] = 1'b1;
        else
        begin
            case (c)
                "+": op_keys[OP_ADD] = 1'b1;
                "-": op_keys[OP_SUB] = 1'b1;
                "*": op_keys[OP_MUL] = 1'b1;
                "/": op_keys[OP_DIV] = 1'b1;
                default: op_keys[OP_EQU] = 1'b1;
            endcase
        end
        repeat (hold) @(negedge rst);
        digit_keys = '0;
        op_keys = '0;
        repeat (4) @(negedge rst);
    endtask

    task automatic run_case(input string name, input string keys, input int hold,
                            input logic signed [31:0] exp_val, input bit exp_neg,
                            input bit exp_err);
        int             target;
        longint         mag;
        target = done_count + 1;
        cur_case = name;
        for (int i = 0; i < keys.len(); i++)
            press_key(keys[i], hold);
        wait (done_count >= target);
        repeat (4) @(negedge rst);   // let the handshake finish
        mag = (exp_val < 0) ? -longint'(exp_val) : longint'(exp_val);
        check({name, " done count"}, target, done_count);
        check({name, " bcd"}, to_bcd(mag), result_bcd);
        check({name, " neg"}, exp_neg, result_neg);
        check({name, " err"}, exp_err, result_err);
    endtask

    initial
    begin
        string              keys;
        string              name;
        int unsigned        a;
        int unsigned        b;
        int unsigned        op;
        logic signed [31:0] exp_val;
        logic               exp_err;
        clk_100hz = 1'b1;
        digit_keys = '0;
        op_keys = '0;
        repeat (10) @(negedge rst);
        clk_100hz = 1'b0;
        repeat (20) @(negedge rst);
        check("reset bcd", 0, result_bcd);
        check("reset neg", 0, result_neg);
        check("reset err", 0, result_err);
        check("reset done count", 0, done_count);

        for (int n = 0; n < N_TAB; n++)
            run_case(tab_keys[n], tab_keys[n], tab_hold[n], tab_val[n], tab_neg[n], tab_err[n]);

        for (int n = 0; n < N_RND; n++)
        begin
            a = rand_bits(13);   // at most 8191
            op = rand_bits(2);
            b = rand_bits(13);
            keys = $sformatf("%0d%c%0d=", a, op_char(op), b);
            name = $sformatf("rand %0d %s", n, keys);
            model_eval(keys, exp_val, exp_err);
            run_case(name, keys, 5, exp_val, exp_val < 0, exp_err);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    // watchdog
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge rst);
        $display("timeout: result_done never came in case %s", cur_case);
        $display("Test failures found");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+src
src/calc_key_pkg.sv
src/calc_result_pkg.sv
src/calc_result_if.sv
src/key_decode.sv
src/accumulate_execute.sv
src/bcd_result.sv
src/calculator_top.sv
test/calculator_assert.sv
test/calculator_tb.sv
